// ==== rv_pkg.sv ====
package rv_pkg;

    // widths and memory sizes
    localparam int xlen             = 32;
    localparam int imem_depth_words = 256;
    localparam int dmem_depth_words = 256;
    localparam int imem_aw          = $clog2(imem_depth_words); // word index bits
    localparam int dmem_aw          = $clog2(dmem_depth_words);

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011; // addi, slti, ...
    localparam logic [6:0] op_reg    = 7'b0110011; // add, sub, ...

    // alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // immediate layouts
    typedef enum logic [2:0] {
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4 // link address for jal / jalr
    } wb_sel_e;

    // operand a source
    typedef enum logic {
        a_reg,
        a_pc
    } a_sel_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

endpackage

// ==== rv_ctrl_if.sv ====
`timescale 1ns/1ns

// decoded control for one instruction, valid for the whole cycle
interface rv_ctrl_if import rv_pkg::*; ();

    alu_op_e    alu_op;
    a_sel_e     a_sel;
    logic       b_is_imm;      // operand b from immediate
    logic       reg_wr_en;     // already gated by run
    wb_sel_e    wb_sel;
    logic       mem_wr_en;     // already gated by run
    mem_size_e  mem_size;
    logic       load_unsigned; // lbu / lhu
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic [2:0] funct3;        // branch condition select

    modport decode_mp (
        output alu_op, a_sel, b_is_imm, reg_wr_en, wb_sel, mem_wr_en,
               mem_size, load_unsigned, is_branch, is_jal, is_jalr, funct3
    );

    modport exec_mp (
        input alu_op, a_sel, b_is_imm, reg_wr_en, wb_sel, mem_wr_en,
              mem_size, load_unsigned, is_branch, is_jal, is_jalr, funct3
    );

    modport mem_mp (
        input mem_wr_en, mem_size, load_unsigned
    );

endinterface

// ==== rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            trigger_i,
    input  logic            imem_wr_en_i,
    input  logic [xlen-1:0] imem_addr_i, // byte address, low two bits ignored
    input  logic [xlen-1:0] imem_data_i,
    input  logic            redirect_i,  // taken branch or jump
    input  logic [xlen-1:0] target_i,
    output logic            run_o,
    output logic [xlen-1:0] pc_o,
    output logic [xlen-1:0] pc_plus4_o,
    output logic [xlen-1:0] instr_o
);

    logic            run_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] imem [imem_depth_words]; // program store, no reset

    // run latch, sticky until rst
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q <= 1'b0;
        end else if (trigger_i) begin
            run_q <= 1'b1;
        end
    end

    assign pc_plus4_o = pc_q + xlen'(4);

    // pc only moves while running, one instruction per edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (run_q) begin
            pc_q <= redirect_i ? target_i : pc_plus4_o;
        end
    end

    // load port, locked out once the core runs
    always_ff @(posedge clk) begin
        if (imem_wr_en_i && !run_q) begin
            imem[imem_addr_i[imem_aw+1:2]] <= imem_data_i;
        end
    end

    assign instr_o = imem[pc_q[imem_aw+1:2]]; // async read, word index
    assign run_o   = run_q;
    assign pc_o    = pc_q;

    // program must be loaded before the trigger, not during the run
    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (rst) !(run_q && imem_wr_en_i));

    // targets from decode/execute keep the pc on a word boundary
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  logic [xlen-1:0] instr_i,
    input  logic            run_i,
    rv_ctrl_if.decode_mp    ctrl,
    output logic [xlen-1:0] imm_o,
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    output logic [4:0]      rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_b5;   // instr[30], sub / sra select
    imm_fmt_e   imm_fmt;
    logic       reg_wr;  // before run gating
    logic       mem_wr;

    // funct3 to alu op, shared by op_imm and op_reg
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign f7_b5  = instr_i[30];

    // lui adds its immediate to x0, its rs1 field is immediate bits
    assign rs1_o = (opcode == op_lui) ? 5'd0 : instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    assign ctrl.funct3 = funct3; // branch condition

    always_comb begin
        ctrl.alu_op        = alu_add; // address and link sums
        ctrl.a_sel         = a_reg;
        ctrl.b_is_imm      = 1'b1;
        ctrl.wb_sel        = wb_alu;
        ctrl.mem_size      = mem_size_e'(funct3[1:0]);
        ctrl.load_unsigned = funct3[2]; // lbu / lhu
        ctrl.is_branch     = 1'b0;
        ctrl.is_jal        = 1'b0;
        ctrl.is_jalr       = 1'b0;
        imm_fmt            = fmt_i;
        reg_wr             = 1'b0;
        mem_wr             = 1'b0;
        case (opcode)
            op_lui: begin
                imm_fmt = fmt_u;
                reg_wr  = 1'b1;
            end
            op_auipc: begin
                ctrl.a_sel = a_pc;
                imm_fmt    = fmt_u;
                reg_wr     = 1'b1;
            end
            op_jal: begin
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = wb_pc4;
                imm_fmt     = fmt_j;
                reg_wr      = 1'b1;
            end
            op_jalr: begin
                ctrl.is_jalr = 1'b1; // target from alu sum
                ctrl.wb_sel  = wb_pc4;
                reg_wr       = 1'b1;
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
                imm_fmt        = fmt_b;
            end
            op_load: begin
                ctrl.wb_sel = wb_load;
                reg_wr      = 1'b1;
            end
            op_store: begin
                imm_fmt = fmt_s;
                mem_wr  = 1'b1;
            end
            op_imm: begin
                // only srai uses the alt bit, addi with imm[10] set stays add
                ctrl.alu_op = alu_from_funct3(funct3, f7_b5 && funct3 == 3'b101);
                reg_wr      = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op   = alu_from_funct3(funct3, f7_b5);
                ctrl.b_is_imm = 1'b0; // rs2 operand
                reg_wr        = 1'b1;
            end
            default: ; // unsupported opcode, no side effects
        endcase
        a_wr_exclusive: assert (!(reg_wr && mem_wr));
    end

    // nothing is written until the core runs
    assign ctrl.reg_wr_en = reg_wr && run_i;
    assign ctrl.mem_wr_en = mem_wr && run_i;

    // immediate assembly, sign from instr[31]
    always_comb begin
        case (imm_fmt)
            fmt_s:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            fmt_b:   imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                              instr_i[30:25], instr_i[11:8], 1'b0};
            fmt_u:   imm_o = {instr_i[31:12], 12'b0};
            fmt_j:   imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                              instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]}; // i format
        endcase
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic            wr_en_i,
    input  logic [xlen-1:0] wr_data_i,
    output logic [xlen-1:0] rs1_data_o,
    output logic [xlen-1:0] rs2_data_o,
    output logic [xlen-1:0] a0_o
);

    logic [xlen-1:0] regs [32];

    // whole file cleared on reset, so a0 starts at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && rd_i != 5'd0) begin // x0 never written
            regs[rd_i] <= wr_data_i;
        end
    end

    // async reads, x0 forced to zero
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

    assign a0_o = regs[10]; // x10 / a0 tap

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    rv_ctrl_if.exec_mp      ctrl,
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] pc_plus4_i,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    input  logic [xlen-1:0] imm_i,
    input  logic [xlen-1:0] load_data_i,
    output logic [xlen-1:0] alu_result_o,
    output logic            redirect_o,
    output logic [xlen-1:0] target_o,
    output logic [xlen-1:0] wb_data_o
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            taken;

    // lui reaches here with rs1 forced to x0, so op_a is zero
    assign op_a  = (ctrl.a_sel == a_pc) ? pc_i : rs1_data_i; // pc for auipc
    assign op_b  = ctrl.b_is_imm ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result_o = op_a + op_b;
            alu_sub:  alu_result_o = op_a - op_b;
            alu_and:  alu_result_o = op_a & op_b;
            alu_or:   alu_result_o = op_a | op_b;
            alu_xor:  alu_result_o = op_a ^ op_b;
            alu_slt:  alu_result_o = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result_o = xlen'(op_a < op_b);
            alu_sll:  alu_result_o = op_a << shamt;
            alu_srl:  alu_result_o = op_a >> shamt;
            alu_sra:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
            default:  alu_result_o = op_a + op_b;
        endcase
    end

    // branch compare on the raw register values
    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rs1_data_i == rs2_data_i);                  // beq
            3'b001:  taken = (rs1_data_i != rs2_data_i);                  // bne
            3'b100:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i)); // blt
            3'b101:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            3'b110:  taken = (rs1_data_i < rs2_data_i);                   // bltu
            3'b111:  taken = (rs1_data_i >= rs2_data_i);                  // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken);

    // jalr uses the alu sum rs1 + imm, lsb dropped
    assign target_o = ctrl.is_jalr ? {alu_result_o[xlen-1:1], 1'b0} : pc_i + imm_i;

    always_comb begin
        case (ctrl.wb_sel)
            wb_load: wb_data_o = load_data_i;
            wb_pc4:  wb_data_o = pc_plus4_i; // link
            default: wb_data_o = alu_result_o;
        endcase
    end

endmodule

// ==== rv_data_mem.sv ====
`timescale 1ns/1ns

module rv_data_mem import rv_pkg::*; (
    input  logic            clk,
    rv_ctrl_if.mem_mp       ctrl,
    input  logic [xlen-1:0] addr_i,    // byte address
    input  logic [xlen-1:0] wr_data_i, // unshifted store data
    output logic [xlen-1:0] rd_data_o
);

    logic [xlen-1:0]    mem [dmem_depth_words]; // no reset on data contents
    logic [dmem_aw-1:0] word_idx;
    logic [3:0]         byte_en;
    logic [xlen-1:0]    wr_lanes;
    logic [xlen-1:0]    rd_word;
    logic [xlen-1:0]    rd_shift;

    assign word_idx = addr_i[dmem_aw+1:2];

    // lane enables from size and offset
    always_comb begin
        case (ctrl.mem_size)
            size_byte: byte_en = 4'b0001 << addr_i[1:0];
            size_half: byte_en = 4'b0011 << {addr_i[1], 1'b0};
            default:   byte_en = 4'b1111;
        endcase
    end

    assign wr_lanes = wr_data_i << {addr_i[1:0], 3'b000}; // move data onto its lanes

    always_ff @(posedge clk) begin
        if (ctrl.mem_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[word_idx][8*b +: 8] <= wr_lanes[8*b +: 8];
            end
        end
    end

    // combinational read, addressed byte/half brought down to bit 0
    assign rd_word  = mem[word_idx];
    assign rd_shift = rd_word >> {addr_i[1:0], 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            size_byte: rd_data_o = ctrl.load_unsigned ? {24'b0, rd_shift[7:0]}
                                                      : {{24{rd_shift[7]}}, rd_shift[7:0]};
            size_half: rd_data_o = ctrl.load_unsigned ? {16'b0, rd_shift[15:0]}
                                                      : {{16{rd_shift[15]}}, rd_shift[15:0]};
            default:   rd_data_o = rd_word;
        endcase
    end

    // no misaligned stores, there is no trap path for them
    a_half_aligned: assert property (
        @(posedge clk) (ctrl.mem_wr_en && ctrl.mem_size == size_half) |-> !addr_i[0]);
    a_word_aligned: assert property (
        @(posedge clk) (ctrl.mem_wr_en && ctrl.mem_size == size_word) |-> addr_i[1:0] == 2'b00);

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            trigger_i,    // starts execution, latched
    input  logic            imem_wr_en_i, // program load, only while idle
    input  logic [xlen-1:0] imem_addr_i,  // byte address
    input  logic [xlen-1:0] imem_data_i,
    output logic [xlen-1:0] pc_o,
    output logic [xlen-1:0] a0_o
);

    logic            run;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] instr;
    logic            redirect;
    logic [xlen-1:0] target;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1, rs2, rd;
    logic [xlen-1:0] rs1_data, rs2_data;
    logic [xlen-1:0] alu_result; // also the data memory address
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;

    rv_ctrl_if ctrl_if ();

    rv_fetch u_rv_fetch (
        .clk          (clk),
        .rst          (rst),
        .trigger_i    (trigger_i),
        .imem_wr_en_i (imem_wr_en_i),
        .imem_addr_i  (imem_addr_i),
        .imem_data_i  (imem_data_i),
        .redirect_i   (redirect),
        .target_i     (target),
        .run_o        (run),
        .pc_o         (pc_o),
        .pc_plus4_o   (pc_plus4),
        .instr_o      (instr)
    );

    rv_decode u_rv_decode (
        .instr_i (instr),
        .run_i   (run),
        .ctrl    (ctrl_if.decode_mp),
        .imm_o   (imm),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .rd_o    (rd)
    );

    rv_regfile u_rv_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .wr_en_i    (ctrl_if.reg_wr_en),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .a0_o       (a0_o)
    );

    rv_execute u_rv_execute (
        .ctrl         (ctrl_if.exec_mp),
        .pc_i         (pc_o),
        .pc_plus4_i   (pc_plus4),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .load_data_i  (load_data),
        .alu_result_o (alu_result),
        .redirect_o   (redirect),
        .target_o     (target),
        .wb_data_o    (wb_data)
    );

    rv_data_mem u_rv_data_mem (
        .clk       (clk),
        .ctrl      (ctrl_if.mem_mp),
        .addr_i    (alu_result),
        .wr_data_i (rs2_data), // store data straight from rs2
        .rd_data_o (load_data)
    );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

    localparam int          timeout_cycles = 2000; // test list needs about 900 cycles
    localparam logic [31:0] lfsr_seed      = 32'd29305;
    localparam logic [31:0] lfsr_taps      = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

    // rv32i major opcodes
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_reg   = 7'b0110011;

    // instructions retired before each program parks
    localparam int n_hold_nops = 4;
    localparam int n_alu_reg   = 5;
    localparam int n_alu_imm   = 3;
    localparam int n_lui       = 1;
    localparam int n_auipc     = 3;
    localparam int n_mem       = 4;
    localparam int n_br_taken  = 6;
    localparam int n_br_fall   = 7;
    localparam int n_jal       = 3;
    localparam int n_jalr      = 2;

    // add sub and or xor slt sltu sll srl sra
    localparam logic [2:0] alu_f3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    localparam logic [6:0] alu_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                                           7'h00, 7'h00, 7'h20};
    // beq bne blt bge bltu bgeu
    localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic        clk          = 1'b0;
    logic        rst          = 1'b1;
    logic        trigger_i    = 1'b0;
    logic        imem_wr_en_i = 1'b0;
    logic [31:0] imem_addr_i  = '0;
    logic [31:0] imem_data_i  = '0;
    logic [31:0] pc_o;
    logic [31:0] a0_o;

    logic [31:0] prog [$];              // program image from address 0
    logic [31:0] lfsr_state  = lfsr_seed;
    int          cycle_count = 0;
    int          test_errors = 0;       // mismatches in the running test
    int          pass_count  = 0;
    int          fail_count  = 0;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .rst          (rst),
        .trigger_i    (trigger_i),
        .imem_wr_en_i (imem_wr_en_i),
        .imem_addr_i  (imem_addr_i),
        .imem_data_i  (imem_data_i),
        .pc_o         (pc_o),
        .a0_o         (a0_o)
    );

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the test list did not complete", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    // instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] nop();
        return i_type(12'd0, 5'd0, 3'd0, 5'd0, opc_imm); // addi x0, x0, 0
    endfunction

    function automatic logic [31:0] self_jump();
        return j_type(21'd0, 5'd0); // jal x0, 0 parks the core
    endfunction

    // expected alu result from rv32i semantics
    function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return {31'b0, $signed(a) < $signed(b)};
            6:       return {31'b0, a < b};
            7:       return a << b[4:0];
            8:       return a >> b[4:0];
            default: return $unsigned($signed(a) >>> b[4:0]);
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input int f3, input int off, input logic [31:0] w);
        logic [31:0] s;
        s = w >> (8 * off); // addressed lane down to bit 0
        case (f3)
            0:       return {{24{s[7]}}, s[7:0]};   // lb
            1:       return {{16{s[15]}}, s[15:0]}; // lh
            4:       return {24'b0, s[7:0]};        // lbu
            5:       return {16'b0, s[15:0]};       // lhu
            default: return w;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // lui + addi, addi sign extends so the upper part absorbs the carry
    task automatic push_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {{20{value[11]}}, value[11:0]};
        hi = value - lo;
        prog.push_back(u_type(hi[31:12], rd, opc_lui));
        prog.push_back(i_type(value[11:0], rd, 3'd0, rd, opc_imm));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%-16s ok", name);
            pass_count++;
        end else begin
            $display("%-16s failed, %0d mismatches", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst          <= 1'b1;
        trigger_i    <= 1'b0;
        imem_wr_en_i <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            imem_wr_en_i <= 1'b1;
            imem_addr_i  <= 32'(4 * i);
            imem_data_i  <= prog[i];
        end
        @(posedge clk); // last word lands here
        imem_wr_en_i <= 1'b0;
    endtask

    task automatic start_and_wait(input int n);
        @(posedge clk);
        trigger_i <= 1'b1;
        @(posedge clk); // run latch sets on this edge
        trigger_i <= 1'b0;
        repeat (n) @(posedge clk);
        @(negedge clk); // sample between edges
    endtask

    task automatic run_program(input int n);
        reset_core();
        load_program();
        start_and_wait(n);
    endtask

    task automatic hold_until_trigger();
        prog.delete();
        repeat (n_hold_nops) prog.push_back(nop());
        prog.push_back(self_jump()); // at 16
        reset_core();
        load_program();
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            check_word("pc_o", 32'd0, pc_o); // no trigger yet
        end
        @(posedge clk);
        trigger_i <= 1'b1;
        @(posedge clk);
        trigger_i <= 1'b0;
        for (int k = 1; k <= n_hold_nops + 2; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_word("pc_o", 32'(4 * ((k < n_hold_nops) ? k : n_hold_nops)), pc_o);
        end
        finish_test("hold_trigger");
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        for (int op = 0; op < 10; op++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            prog.delete();
            push_li(5'd5, a);
            push_li(5'd6, b);
            prog.push_back(r_type(alu_f7[op], 5'd6, 5'd5, alu_f3[op], 5'd10, opc_reg));
            prog.push_back(self_jump());
            run_program(n_alu_reg);
            check_word("a0_o", alu_ref(op, a, b), a0_o);
            if (op != 1) begin // rv32i has no subi
                if (alu_f3[op] == 3'd1 || alu_f3[op] == 3'd5) begin
                    b   = rand_bits(5);
                    imm = {alu_f7[op], b[4:0]}; // shamt, bit 10 picks srai
                end else begin
                    b   = rand_bits(12);
                    imm = b[11:0];
                    b   = {{20{imm[11]}}, imm};
                end
                prog.delete();
                push_li(5'd5, a);
                prog.push_back(i_type(imm, 5'd5, alu_f3[op], 5'd10, opc_imm));
                prog.push_back(self_jump());
                run_program(n_alu_imm);
                check_word("a0_o", alu_ref(op, a, b), a0_o);
            end
        end
        finish_test("alu_ops");
    endtask

    task automatic upper_immediates();
        logic [31:0] u;
        u = rand_bits(20);
        prog.delete();
        prog.push_back(u_type(u[19:0], 5'd10, opc_lui));
        prog.push_back(self_jump());
        run_program(n_lui);
        check_word("a0_o", {u[19:0], 12'b0}, a0_o);
        u = rand_bits(20);
        prog.delete();
        prog.push_back(nop());
        prog.push_back(nop());
        prog.push_back(u_type(u[19:0], 5'd10, opc_auipc)); // at 8
        prog.push_back(self_jump());
        run_program(n_auipc);
        check_word("a0_o", 32'd8 + {u[19:0], 12'b0}, a0_o);
        finish_test("lui_auipc");
    endtask

    task automatic store_load();
        logic [31:0] w;
        for (int f3 = 0; f3 < 6; f3++) begin
            for (int off = 0; off < 4; off++) begin
                if (f3 != 3 && (off % (1 << (f3 % 4))) == 0) begin // aligned cases only
                    w = rand_bits(32);
                    prog.delete();
                    push_li(5'd5, w);
                    prog.push_back(s_type(12'h100, 5'd5, 5'd0, 3'd2)); // sw to 0x100
                    prog.push_back(i_type(12'(256 + off), 5'd0, 3'(f3), 5'd10, opc_load));
                    prog.push_back(self_jump());
                    run_program(n_mem);
                    check_word("a0_o", load_ref(f3, off, w), a0_o);
                end
            end
        end
        finish_test("store_load");
    endtask

    task automatic branch_conditions();
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        for (int c = 0; c < 6; c++) begin
            for (int same = 0; same < 2; same++) begin
                a     = rand_bits(32);
                b     = (same == 1) ? a : rand_bits(32); // equal pair flips beq / bne
                taken = branch_ref(br_f3[c], a, b);
                prog.delete();
                push_li(5'd5, a);
                push_li(5'd6, b);
                prog.push_back(i_type(12'd1, 5'd0, 3'd0, 5'd10, opc_imm)); // a0 = 1
                prog.push_back(b_type(13'd12, 5'd6, 5'd5, br_f3[c]));      // at 20, to 32
                prog.push_back(i_type(12'd2, 5'd0, 3'd0, 5'd10, opc_imm)); // skipped if taken
                prog.push_back(self_jump());                              // fall-through park
                prog.push_back(self_jump());                              // taken park
                run_program(taken ? n_br_taken : n_br_fall);
                check_word("a0_o", taken ? 32'd1 : 32'd2, a0_o);
                check_word("pc_o", taken ? 32'd32 : 32'd28, pc_o);
            end
        end
        finish_test("branches");
    endtask

    task automatic jumps();
        logic [31:0] r;
        logic [31:0] t;
        logic [31:0] imm;
        logic [31:0] base;
        prog.delete();
        prog.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd1, opc_imm));
        prog.push_back(i_type(12'd6, 5'd0, 3'd0, 5'd2, opc_imm));
        prog.push_back(j_type(21'd12, 5'd10));                     // at 8, to 20
        prog.push_back(i_type(12'd1, 5'd0, 3'd0, 5'd10, opc_imm)); // skipped
        prog.push_back(self_jump());
        prog.push_back(self_jump());                               // at 20
        run_program(n_jal);
        check_word("a0_o", 32'd12, a0_o);
        check_word("pc_o", 32'd20, pc_o);
        r    = rand_bits(3);
        t    = 32'd4 + r;         // target word 4..11
        imm  = rand_bits(4);
        base = 4 * t + 1 - imm;   // odd sum, bit 0 must drop
        prog.delete();
        prog.push_back(i_type(base[11:0], 5'd0, 3'd0, 5'd5, opc_imm));
        prog.push_back(i_type(imm[11:0], 5'd5, 3'd0, 5'd10, opc_jalr)); // at 4
        repeat (14) prog.push_back(self_jump());                        // 8 to 60
        run_program(n_jalr);
        check_word("a0_o", 32'd8, a0_o);
        check_word("pc_o", 4 * t, pc_o);
        finish_test("jal_jalr");
    endtask

    initial begin
        hold_until_trigger();
        alu_ops();
        upper_immediates();
        store_load();
        branch_conditions();
        jumps();
        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
rv_pkg.sv
rv_ctrl_if.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_data_mem.sv
rv_core_top.sv
tb_rv_core.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb_rv_core
FILELIST ?= rv_core.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
